/* memory.hex */
// one 64-bit doubleword per line, word address 0 to 63 in order
00FF5A00C3FF0096
01FE5A01C3FE0196
02FD5A02C3FD0296
03FC5A03C3FC0396
04FB5A04C3FB0496
05FA5A05C3FA0596
06F95A06C3F90696
07F85A07C3F80796
08F75A08C3F70896
09F65A09C3F60996
0AF55A0AC3F50A96
0BF45A0BC3F40B96
0CF35A0CC3F30C96
0DF25A0DC3F20D96
0EF15A0EC3F10E96
0FF05A0FC3F00F96
10EF5A10C3EF1096
11EE5A11C3EE1196
12ED5A12C3ED1296
13EC5A13C3EC1396
14EB5A14C3EB1496
15EA5A15C3EA1596
16E95A16C3E91696
17E85A17C3E81796
18E75A18C3E71896
19E65A19C3E61996
1AE55A1AC3E51A96
1BE45A1BC3E41B96
1CE35A1CC3E31C96
1DE25A1DC3E21D96
1EE15A1EC3E11E96
1FE05A1FC3E01F96
20DF5A20C3DF2096
21DE5A21C3DE2196
22DD5A22C3DD2296
23DC5A23C3DC2396
24DB5A24C3DB2496
25DA5A25C3DA2596
26D95A26C3D92696
27D85A27C3D82796
28D75A28C3D72896
29D65A29C3D62996
2AD55A2AC3D52A96
2BD45A2BC3D42B96
2CD35A2CC3D32C96
2DD25A2DC3D22D96
2ED15A2EC3D12E96
2FD05A2FC3D02F96
30CF5A30C3CF3096
31CE5A31C3CE3196
32CD5A32C3CD3296
33CC5A33C3CC3396
34CB5A34C3CB3496
35CA5A35C3CA3596
36C95A36C3C93696
37C85A37C3C83796
38C75A38C3C73896
39C65A39C3C63996
3AC55A3AC3C53A96
3BC45A3BC3C43B96
3CC35A3CC3C33C96
3DC25A3DC3C23D96
3EC15A3EC3C13E96
3FC05A3FC3C03F96

/* verilog.f */
source/fetch_pkg.sv
source/miss_tracker.sv
source/icache.sv
source/tagged_memory.sv
source/fetch_top.sv
tb/fetch_tb.sv

/* Bender.yml */
package:
  name: fetch_icache

sources:
  - files:
      - source/fetch_pkg.sv
      - source/miss_tracker.sv
      - source/icache.sv
      - source/tagged_memory.sv
      - source/fetch_top.sv
  - target: simulation
    files:
      - tb/fetch_tb.sv

/* tb/fetch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_tb
  import fetch_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 200;

  logic                 clock;
  logic                 reset;
  logic [ADDR_BITS-1:0] fetch_addr;
  logic [DATA_BITS-1:0] fetch_data;
  logic                 fetch_valid;

  logic [DATA_BITS-1:0] ref_mem [MEM_WORDS];

  string test_name;
  int    word_errors;
  int    flag_errors;
  int    timeout_errors;
  int    latency_errors;
  int    first_cycle_hits;

  fetch_top i_fetch_top (
    .clock         (clock),
    .reset         (reset),
    .i_fetch_addr  (fetch_addr),
    .o_fetch_data  (fetch_data),
    .o_fetch_valid (fetch_valid)
  );

  initial begin
    clock = 1'b0;
    forever begin
      #5 clock = ~clock;
    end
  end

  initial begin
    $readmemh(MEM_FILE, ref_mem);
  end

  // the memory only decodes the low word address bits, so every address aliases.
  function automatic logic [DATA_BITS-1:0] expected_word(input logic [ADDR_BITS-1:0] addr);
    int word_index;
    word_index = (int'(addr) >> OFFSET_BITS) % MEM_WORDS;
    return ref_mem[word_index];
  endfunction

  task automatic check_word(input string name, input logic [DATA_BITS-1:0] expected,
                            input logic [DATA_BITS-1:0] actual);
    if (actual !== expected) begin
      word_errors++;
      $display("mismatch %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      flag_errors++;
      $display("mismatch %s: expected %b, actual %b", name, expected, actual);
    end
  endtask

  // every valid output must carry the word of the address presented in that cycle.
  always @(negedge clock) begin
    if (!reset && fetch_valid === 1'b1) begin
      check_word(test_name, expected_word(fetch_addr), fetch_data);
    end
  end

  task automatic drive_addr(input logic [ADDR_BITS-1:0] addr);
    @(posedge clock);
    #1;
    fetch_addr = addr;
  endtask

  task automatic wait_valid(output int cycles, output bit seen);
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < TIMEOUT_CYCLES) begin
      @(negedge clock);
      if (fetch_valid === 1'b1) begin
        seen = 1'b1;
      end else begin
        cycles++;
      end
    end
    if (!seen) begin
      timeout_errors++;
      $display("%s: address %h did not become valid within %0d cycles",
               test_name, fetch_addr, TIMEOUT_CYCLES);
    end
  endtask

  initial begin
    int          cycles;
    bit          seen;
    fetch_addr_u pair_a;
    fetch_addr_u pair_b;

    void'($urandom(72));
    word_errors      = 0;
    flag_errors      = 0;
    timeout_errors   = 0;
    latency_errors   = 0;
    first_cycle_hits = 0;
    test_name        = "reset";
    reset            = 1'b1;
    fetch_addr       = '0;

    for (int i = 0; i < 16; i++) begin
      drive_addr(ADDR_BITS'($urandom));
      if (i == 15) begin
        reset = 1'b0; // sixteen rising edges have seen reset high.
      end
      @(negedge clock);
      check_flag("reset", 1'b0, fetch_valid);
    end
    // tag zero matches the reset tags, so these leave every slot as it was.
    for (int i = 0; i < 4; i++) begin
      drive_addr(ADDR_BITS'($urandom) & 16'h007f);
      @(negedge clock);
      check_flag("after_reset", 1'b0, fetch_valid);
    end

    test_name = "cold_miss";
    drive_addr(16'h0098);
    wait_valid(cycles, seen);
    if (seen && cycles < MEM_LATENCY + 1) begin
      latency_errors++;
      $display("cold_miss: data became valid after %0d cycles, sooner than the memory latency",
               cycles);
    end

    test_name = "sequential";
    for (int k = 0; k < 40; k++) begin
      drive_addr(16'h0100 + ADDR_BITS'(8 * k));
      wait_valid(cycles, seen);
      if (seen && cycles == 0) begin
        first_cycle_hits++;
      end
    end
    $display("sequential: %0d of 40 words hit on the first cycle", first_cycle_hits);

    test_name = "conflict";
    for (int p = 0; p < 4; p++) begin
      pair_a.raw        = ADDR_BITS'($urandom);
      pair_b            = pair_a;
      pair_b.fields.tag = pair_a.fields.tag ^ TAG_BITS'(1 + p % 3);
      // switching every cycle leaves loads for both tags in flight.
      for (int n = 0; n < 12; n++) begin
        drive_addr(n[0] ? pair_b.raw : pair_a.raw);
      end
      for (int n = 0; n < 4; n++) begin
        drive_addr(n[0] ? pair_b.raw : pair_a.raw);
        wait_valid(cycles, seen);
      end
    end

    test_name = "random";
    for (int n = 0; n < 100; n++) begin
      drive_addr(ADDR_BITS'($urandom));
      wait_valid(cycles, seen);
    end

    test_name = "held_hit";
    drive_addr(16'h0150);
    wait_valid(cycles, seen);
    repeat (10) begin
      @(negedge clock);
      check_flag("held_hit", 1'b1, fetch_valid);
      check_word("held_hit", expected_word(16'h0150), fetch_data);
    end

    $display("errors: word %0d, flag %0d, timeout %0d, latency %0d",
             word_errors, flag_errors, timeout_errors, latency_errors);
    if (word_errors + flag_errors + timeout_errors + latency_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* source/fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_top import fetch_pkg::*; (
  input  logic                 clock,
  input  logic                 reset,
  input  logic [ADDR_BITS-1:0] i_fetch_addr,
  output logic [DATA_BITS-1:0] o_fetch_data,
  output logic                 o_fetch_valid
);

  logic [1:0]              mem_command;
  logic [ADDR_BITS-1:0]    mem_addr;
  logic [MEM_TAG_BITS-1:0] mem_response;
  logic [DATA_BITS-1:0]    mem_data;
  logic [MEM_TAG_BITS-1:0] mem_tag;

  icache i_icache (
    .clock          (clock),
    .reset          (reset),
    .i_fetch_addr   (i_fetch_addr),
    .i_mem_response (mem_response),
    .i_mem_data     (mem_data),
    .i_mem_tag      (mem_tag),
    .o_mem_command  (mem_command),
    .o_mem_addr     (mem_addr),
    .o_fetch_data   (o_fetch_data),
    .o_fetch_valid  (o_fetch_valid)
  );

  tagged_memory i_tagged_memory (
    .clock          (clock),
    .reset          (reset),
    .i_mem_command  (mem_command),
    .i_mem_addr     (mem_addr),
    .o_mem_response (mem_response),
    .o_mem_data     (mem_data),
    .o_mem_tag      (mem_tag)
  );

endmodule

`default_nettype wire

/* source/tagged_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module tagged_memory import fetch_pkg::*; (
  input  logic                    clock,
  input  logic                    reset,
  input  logic [1:0]              i_mem_command,
  input  logic [ADDR_BITS-1:0]    i_mem_addr,
  output logic [MEM_TAG_BITS-1:0] o_mem_response,
  output logic [DATA_BITS-1:0]    o_mem_data,
  output logic [MEM_TAG_BITS-1:0] o_mem_tag
);

  logic [DATA_BITS-1:0] mem [MEM_WORDS];

  logic [NUM_MEM_TAGS-1:0]                  free_mask;
  logic [NUM_MEM_TAGS-1:0]                  free_next;
  logic [MEM_TAG_BITS-1:0]                  next_tag;
  logic [MEM_TAG_BITS-1:0]                  grant;
  logic [MEM_LATENCY-1:0][MEM_TAG_BITS-1:0] pipe_tag;
  logic [MEM_LATENCY-1:0][WORD_BITS-1:0]    pipe_word;

  initial begin
    $readmemh(MEM_FILE, mem);
  end

  // pick the first free tag at or after next_tag, wrapping within 1 to 15.
  always_comb begin
    int cand;
    grant = '0;
    for (int k = NUM_MEM_TAGS - 2; k >= 0; k--) begin
      cand = (int'(next_tag) - 1 + k) % (NUM_MEM_TAGS - 1) + 1;
      if (free_mask[cand]) begin
        grant = MEM_TAG_BITS'(cand);
      end
    end
  end

  assign o_mem_response = (i_mem_command == BUS_LOAD) ? grant : '0;

  assign o_mem_tag  = pipe_tag[MEM_LATENCY-1];
  assign o_mem_data = mem[pipe_word[MEM_LATENCY-1]];

  always_comb begin
    free_next = free_mask;
    if (o_mem_response != '0) begin
      free_next[o_mem_response] = 1'b0;
    end
    if (o_mem_tag != '0) begin
      free_next[o_mem_tag] = 1'b1; // usable again from the next cycle.
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      free_mask <= {{(NUM_MEM_TAGS-1){1'b1}}, 1'b0};
      next_tag  <= MEM_TAG_BITS'(1);
      pipe_tag  <= '0;
    end else begin
      free_mask <= free_next;
      if (o_mem_response != '0) begin
        if (o_mem_response == MEM_TAG_BITS'(NUM_MEM_TAGS - 1)) begin
          next_tag <= MEM_TAG_BITS'(1);
        end else begin
          next_tag <= o_mem_response + 1'b1;
        end
      end
      pipe_tag <= {pipe_tag[MEM_LATENCY-2:0], o_mem_response};
    end
  end

  // word addresses follow the tags down the pipeline.
  always_ff @(posedge clock) begin
    pipe_word <= {pipe_word[MEM_LATENCY-2:0], i_mem_addr[OFFSET_BITS +: WORD_BITS]};
  end

endmodule

`default_nettype wire

/* source/icache.sv */
`timescale 1ns/1ps
`default_nettype none

module icache import fetch_pkg::*; (
  input  logic                    clock,
  input  logic                    reset,
  input  logic [ADDR_BITS-1:0]    i_fetch_addr,
  input  logic [MEM_TAG_BITS-1:0] i_mem_response,
  input  logic [DATA_BITS-1:0]    i_mem_data,
  input  logic [MEM_TAG_BITS-1:0] i_mem_tag,
  output logic [1:0]              o_mem_command,
  output logic [ADDR_BITS-1:0]    o_mem_addr,
  output logic [DATA_BITS-1:0]    o_fetch_data,
  output logic                    o_fetch_valid
);

  fetch_addr_u fetch;
  fetch_addr_u req_addr;

  logic [ICACHE_LINES-1:0]               line_valid;
  logic [ICACHE_LINES-1:0][TAG_BITS-1:0] line_tag;
  logic [DATA_BITS-1:0]                  line_data [ICACHE_LINES];

  logic [ICACHE_LINES-1:0]               valid_next;
  logic [ICACHE_LINES-1:0][TAG_BITS-1:0] slot_tags_next;

  logic [IDX_BITS-1:0] head, tail;
  logic [IDX_BITS-1:0] head_next, tail_next;
  logic [IDX_BITS-1:0] tail_plus_one, idx_plus_one;

  logic                tag_match;
  logic                accepted;
  logic                fill;
  logic [IDX_BITS-1:0] fill_idx;

  assign fetch.raw = i_fetch_addr;

  assign tag_match     = line_tag[fetch.fields.idx] == fetch.fields.tag;
  assign o_fetch_valid = tag_match && line_valid[fetch.fields.idx];
  assign o_fetch_data  = line_data[fetch.fields.idx];

  assign accepted      = i_mem_response != '0;
  assign tail_plus_one = tail + 1'b1;
  assign idx_plus_one  = fetch.fields.idx + 1'b1;

  // on a hit the next line of the prefetch window goes out instead.
  always_comb begin
    req_addr.fields.offset = '0;
    if (tag_match) begin
      req_addr.fields.tag = line_tag[tail];
      req_addr.fields.idx = tail;
    end else begin
      req_addr.fields.tag = fetch.fields.tag;
      req_addr.fields.idx = fetch.fields.idx;
    end
  end

  assign o_mem_addr = req_addr.raw;

  always_comb begin
    head_next = head;
    tail_next = tail;
    if (!tag_match) begin
      head_next = fetch.fields.idx;
      tail_next = accepted ? idx_plus_one : fetch.fields.idx; // refused loads retry here.
    end else if (accepted && tail_plus_one != head) begin
      tail_next = tail_plus_one;
    end
  end

  // the tracker compares against the tags as they will be after this edge.
  always_comb begin
    slot_tags_next = line_tag;
    slot_tags_next[fetch.fields.idx] = fetch.fields.tag;
  end

  always_comb begin
    valid_next = line_valid;
    if (!tag_match) begin
      valid_next[fetch.fields.idx] = 1'b0;
    end
    if (fill) begin
      valid_next[fill_idx] = 1'b1;
    end
  end

  miss_tracker i_miss_tracker (
    .clock            (clock),
    .reset            (reset),
    .i_alloc_tag      (i_mem_response),
    .i_alloc_idx      (req_addr.fields.idx),
    .i_alloc_line_tag (req_addr.fields.tag),
    .i_return_tag     (i_mem_tag),
    .i_slot_tags      (slot_tags_next),
    .o_fill           (fill),
    .o_fill_idx       (fill_idx)
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      line_valid    <= '0;
      line_tag      <= '0;
      head          <= '0;
      tail          <= '0;
      o_mem_command <= BUS_NONE;
    end else begin
      line_valid    <= valid_next;
      line_tag      <= slot_tags_next;
      head          <= head_next;
      tail          <= tail_next;
      o_mem_command <= BUS_LOAD; // the cache always has a line to ask for.
    end
  end

  always_ff @(posedge clock) begin
    if (fill) begin
      line_data[fill_idx] <= i_mem_data;
    end
  end

endmodule

`default_nettype wire

/* source/miss_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module miss_tracker import fetch_pkg::*; (
  input  logic                                   clock,
  input  logic                                   reset,
  input  logic [MEM_TAG_BITS-1:0]                i_alloc_tag,
  input  logic [IDX_BITS-1:0]                    i_alloc_idx,
  input  logic [TAG_BITS-1:0]                    i_alloc_line_tag,
  input  logic [MEM_TAG_BITS-1:0]                i_return_tag,
  input  logic [ICACHE_LINES-1:0][TAG_BITS-1:0]  i_slot_tags,
  output logic                                   o_fill,
  output logic [IDX_BITS-1:0]                    o_fill_idx
);

  logic [NUM_MEM_TAGS-1:0]               entry_valid;
  logic [NUM_MEM_TAGS-1:0][IDX_BITS-1:0] entry_idx;
  logic [NUM_MEM_TAGS-1:0][TAG_BITS-1:0] entry_line_tag;

  logic                returning;
  logic [TAG_BITS-1:0] current_tag;

  assign returning   = i_return_tag != '0;
  assign o_fill_idx  = entry_idx[i_return_tag];
  assign current_tag = i_slot_tags[o_fill_idx];

  // a fill is dropped if the slot was retagged since the load went out.
  assign o_fill = returning && entry_valid[i_return_tag]
                  && (entry_line_tag[i_return_tag] == current_tag);

  always_ff @(posedge clock) begin
    if (reset) begin
      entry_valid <= '0;
    end else begin
      if (returning) begin
        entry_valid[i_return_tag] <= 1'b0; // retired whether used or not.
      end
      if (i_alloc_tag != '0) begin
        entry_valid[i_alloc_tag] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (i_alloc_tag != '0) begin
      entry_idx[i_alloc_tag]      <= i_alloc_idx;
      entry_line_tag[i_alloc_tag] <= i_alloc_line_tag;
    end
  end

endmodule

`default_nettype wire

/* source/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  // fetch address layout.
  localparam int ADDR_BITS   = 16;
  localparam int OFFSET_BITS = 3;
  localparam int IDX_BITS    = 4;
  localparam int ICACHE_LINES = 1 << IDX_BITS;
  localparam int TAG_BITS    = ADDR_BITS - IDX_BITS - OFFSET_BITS;

  localparam int DATA_BITS = 64; // one doubleword per cache line.

  // memory model sizes.
  localparam int MEM_WORDS    = 64;
  localparam int WORD_BITS    = $clog2(MEM_WORDS);
  localparam int MEM_TAG_BITS = 4;
  localparam int NUM_MEM_TAGS = 1 << MEM_TAG_BITS; // tag 0 means no transaction.
  localparam int MEM_LATENCY  = 4;

  localparam logic [1:0] BUS_NONE = 2'b00;
  localparam logic [1:0] BUS_LOAD = 2'b01;

  localparam string MEM_FILE = "memory.hex";

  // a fetch address seen either as a byte address or split into cache fields.
  typedef union packed {
    logic [ADDR_BITS-1:0] raw;
    struct packed {
      logic [TAG_BITS-1:0]    tag;
      logic [IDX_BITS-1:0]    idx;
      logic [OFFSET_BITS-1:0] offset;
    } fields;
  } fetch_addr_u;

endpackage

`default_nettype wire
